// ==== hw/ctrl_defines.svh ====
// Build-time widths, register count and DRAM window for the SoC control block
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

////////////////////
// Bus widths
////////////////////

// AXI-lite data bus, also the width of every register
`define CTRL_DATA_WIDTH 32

// AXI-lite address bus
`define CTRL_ADDR_WIDTH 32

////////////////////
// Register file
////////////////////

// exit, dram_base, dram_end, hw_cnt_en, cycle_cnt
`define CTRL_NUM_REGS 5

////////////////////
// DRAM window
////////////////////

// Start of DRAM as seen from the host
`define CTRL_DRAM_BASE 32'h8000_0000

// Window size, end register holds base plus length
`define CTRL_DRAM_LENGTH 32'h0100_0000

`endif

// ==== hw/ctrl_pkg.sv ====
// Shared AXI-lite channel types and register indices of the SoC control block
`include "ctrl_defines.svh"

package ctrl_pkg;

  ////////////////////
  // Basic fields
  ////////////////////

  typedef logic [`CTRL_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`CTRL_DATA_WIDTH-1:0]   data_t;
  typedef logic [`CTRL_DATA_WIDTH/8-1:0] strb_t;

  // Hardware cycle counter value
  typedef logic [31:0] cycle_cnt_t;

  // Response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  ////////////////////
  // AXI-lite channels
  ////////////////////

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } axi_lite_aw_t;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } axi_lite_ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } axi_lite_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_lite_b_t;

  typedef struct packed {
    data_t      data;
    logic [1:0] resp;
  } axi_lite_r_t;

  // Host to slave
  typedef struct packed {
    axi_lite_aw_t aw;
    logic         aw_valid;
    axi_lite_w_t  w;
    logic         w_valid;
    logic         b_ready;
    axi_lite_ar_t ar;
    logic         ar_valid;
    logic         r_ready;
  } axi_lite_req_t;

  // Slave to host
  typedef struct packed {
    logic         aw_ready;
    logic         w_ready;
    axi_lite_b_t  b;
    logic         b_valid;
    logic         ar_ready;
    axi_lite_r_t  r;
    logic         r_valid;
  } axi_lite_resp_t;

  // Word index of each control register, byte address is index times 4
  typedef enum logic [2:0] {
    exit      = 3'd0,
    dram_base = 3'd1,
    dram_end  = 3'd2,
    hw_cnt_en = 3'd3,
    cycle_cnt = 3'd4
  } reg_idx_e;

endpackage : ctrl_pkg

// ==== hw/axi_lite_regs.sv ====
// Generic AXI-lite register bank, byte addressed, with read-only masks and hardware load
module axi_lite_regs #(
  parameter int unsigned                     RegNumBytes  = 4,
  parameter int unsigned                     AxiAddrWidth = 32,
  parameter int unsigned                     AxiDataWidth = 32,
  parameter logic [RegNumBytes-1:0]          AxiReadOnly  = '0,
  parameter logic [RegNumBytes-1:0][7:0]     RegRstVal    = '0,
  parameter type                             req_lite_t   = ctrl_pkg::axi_lite_req_t,
  parameter type                             resp_lite_t  = ctrl_pkg::axi_lite_resp_t
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // AXI-lite slave port
  input  req_lite_t                    axi_req_i,
  output resp_lite_t                   axi_resp_o,
  // Bytes written by the bus this cycle
  output logic [RegNumBytes-1:0]       wr_active_o,
  // Hardware side
  input  logic [RegNumBytes-1:0][7:0]  reg_d_i,
  input  logic [RegNumBytes-1:0]       reg_load_i,
  output logic [RegNumBytes-1:0][7:0]  reg_q_o
);

  ////////////////////
  // Definitions
  ////////////////////

  localparam int unsigned StrbWidth  = AxiDataWidth / 8;
  localparam int unsigned AddrOffset = $clog2(StrbWidth);
  localparam int unsigned NumWords   = (RegNumBytes + StrbWidth - 1) / StrbWidth;
  localparam int unsigned WordIdxW   = AxiAddrWidth - AddrOffset;

  logic [RegNumBytes-1:0][7:0] reg_q;

  // Write path
  logic [WordIdxW-1:0]          wr_word;
  logic                         wr_in_range;
  logic [RegNumBytes-1:0]       wr_sel;
  logic                         wr_err;
  logic                         wr_handshake;
  logic [RegNumBytes-1:0]       wr_en;
  logic [StrbWidth-1:0][7:0]    wr_bytes;
  logic                         b_valid_q;
  logic [1:0]                   b_resp_q;

  // Read path
  logic [WordIdxW-1:0]          rd_word;
  logic                         rd_in_range;
  logic [StrbWidth-1:0][7:0]    rd_bytes;
  logic                         rd_handshake;
  logic                         r_valid_q;
  logic [1:0]                   r_resp_q;
  logic [AxiDataWidth-1:0]      r_data_q;

  ////////////////////
  // Write decode
  ////////////////////

  // Low address bits select a byte lane and are ignored
  assign wr_word     = axi_req_i.aw.addr[AxiAddrWidth-1:AddrOffset];
  assign wr_in_range = (wr_word < WordIdxW'(NumWords));
  assign wr_bytes    = axi_req_i.w.data;

  always_comb begin
    for (int unsigned b = 0; b < RegNumBytes; b++) begin
      wr_sel[b] = wr_in_range && (wr_word == WordIdxW'(b / StrbWidth)) &&
                  axi_req_i.w.strb[b % StrbWidth];
    end
  end

  // A single strobed read-only byte rejects the whole write
  assign wr_err = ~wr_in_range | (|(wr_sel & AxiReadOnly));

  // Address and data are taken together, never one without the other
  assign wr_handshake = axi_req_i.aw_valid & axi_req_i.w_valid & ~b_valid_q;
  assign wr_en        = wr_sel & {RegNumBytes{wr_handshake & ~wr_err}};
  assign wr_active_o  = wr_en;

  ////////////////////
  // Register array
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_q <= RegRstVal;
    end else begin
      for (int unsigned b = 0; b < RegNumBytes; b++) begin
        // Hardware load wins over the bus
        if (reg_load_i[b]) begin
          reg_q[b] <= reg_d_i[b];
        end else if (wr_en[b]) begin
          reg_q[b] <= wr_bytes[b % StrbWidth];
        end
      end
    end
  end

  assign reg_q_o = reg_q;

  ////////////////////
  // Read decode
  ////////////////////

  assign rd_word      = axi_req_i.ar.addr[AxiAddrWidth-1:AddrOffset];
  assign rd_in_range  = (rd_word < WordIdxW'(NumWords));
  assign rd_handshake = axi_req_i.ar_valid & ~r_valid_q;

  // Out of range reads return zero
  always_comb begin
    rd_bytes = '0;
    for (int unsigned b = 0; b < RegNumBytes; b++) begin
      if (rd_in_range && (rd_word == WordIdxW'(b / StrbWidth))) begin
        rd_bytes[b % StrbWidth] = reg_q[b];
      end
    end
  end

  ////////////////////
  // Response channels
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (b_valid_q && axi_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end else if (wr_handshake) begin
        b_valid_q <= 1'b1;
      end
      if (r_valid_q && axi_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end else if (rd_handshake) begin
        r_valid_q <= 1'b1;
      end
    end
  end

  // Response payload, only captured on acceptance
  always_ff @(posedge clk_i) begin
    if (wr_handshake) begin
      b_resp_q <= wr_err ? ctrl_pkg::resp_slverr : ctrl_pkg::resp_okay;
    end
    if (rd_handshake) begin
      r_data_q <= rd_bytes;
      r_resp_q <= rd_in_range ? ctrl_pkg::resp_okay : ctrl_pkg::resp_slverr;
    end
  end

  always_comb begin
    axi_resp_o          = '0;
    // Ready is held low while only one of aw and w is valid
    axi_resp_o.aw_ready = ~b_valid_q & ~(axi_req_i.aw_valid ^ axi_req_i.w_valid);
    axi_resp_o.w_ready  = ~b_valid_q & ~(axi_req_i.aw_valid ^ axi_req_i.w_valid);
    axi_resp_o.b.resp   = b_resp_q;
    axi_resp_o.b_valid  = b_valid_q;
    axi_resp_o.ar_ready = ~r_valid_q;
    axi_resp_o.r.data   = r_data_q;
    axi_resp_o.r.resp   = r_resp_q;
    axi_resp_o.r_valid  = r_valid_q;
  end

endmodule : axi_lite_regs

// ==== hw/ctrl_registers.sv ====
// SoC control registers, memory map and exit write reporting over AXI-lite
`include "ctrl_defines.svh"

module ctrl_registers #(
  parameter logic [`CTRL_DATA_WIDTH-1:0] DRAMBaseAddr = `CTRL_DRAM_BASE,
  parameter logic [`CTRL_DATA_WIDTH-1:0] DRAMLength   = `CTRL_DRAM_LENGTH
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // AXI-lite slave port
  input  ctrl_pkg::axi_lite_req_t       axi_lite_slave_req_i,
  output ctrl_pkg::axi_lite_resp_t      axi_lite_slave_resp_o,
  // Hardware counter value
  input  logic [31:0]                   cycle_cnt_i,
  // Register outputs
  output logic [`CTRL_DATA_WIDTH-1:0]   exit_o,
  output logic [`CTRL_DATA_WIDTH-1:0]   dram_base_addr_o,
  output logic [`CTRL_DATA_WIDTH-1:0]   dram_end_addr_o,
  output logic [`CTRL_DATA_WIDTH-1:0]   hw_cnt_en_o
);

  ////////////////////
  // Memory map
  ////////////////////

  localparam int unsigned DataWidth   = `CTRL_DATA_WIDTH;
  localparam int unsigned NumRegs     = `CTRL_NUM_REGS;
  localparam int unsigned BytesPerReg = DataWidth / 8;
  localparam int unsigned RegNumBytes = NumRegs * BytesPerReg;

  typedef logic [NumRegs-1:0][DataWidth-1:0]   reg_words_t;
  typedef logic [NumRegs-1:0][BytesPerReg-1:0] reg_mask_t;

  function automatic reg_words_t reset_values();
    reg_words_t rst;
    rst                      = '0;
    rst[ctrl_pkg::dram_base] = DRAMBaseAddr;
    rst[ctrl_pkg::dram_end]  = DRAMBaseAddr + DRAMLength;
    return rst;
  endfunction

  // DRAM window and cycle count are not writable from the bus
  function automatic reg_mask_t read_only_mask();
    reg_mask_t ro;
    ro                      = '0;
    ro[ctrl_pkg::dram_base] = '1;
    ro[ctrl_pkg::dram_end]  = '1;
    ro[ctrl_pkg::cycle_cnt] = '1;
    return ro;
  endfunction

  function automatic reg_mask_t load_mask();
    reg_mask_t ld;
    ld                      = '0;
    ld[ctrl_pkg::cycle_cnt] = '1;
    return ld;
  endfunction

  localparam reg_words_t RegRstVal   = reset_values();
  localparam reg_mask_t  AxiReadOnly = read_only_mask();
  localparam reg_mask_t  RegLoad     = load_mask();

  reg_words_t                reg_d;
  reg_words_t                reg_q;
  reg_mask_t                 wr_active;
  logic [BytesPerReg-1:0]    exit_wr_q;
  logic                      exit_strobe_q;

  // Counter value refreshed every cycle
  always_comb begin
    reg_d                      = '0;
    reg_d[ctrl_pkg::cycle_cnt] = cycle_cnt_i;
  end

  axi_lite_regs #(
    .RegNumBytes (RegNumBytes),
    .AxiAddrWidth(`CTRL_ADDR_WIDTH),
    .AxiDataWidth(DataWidth),
    .AxiReadOnly (AxiReadOnly),
    .RegRstVal   (RegRstVal),
    .req_lite_t  (ctrl_pkg::axi_lite_req_t),
    .resp_lite_t (ctrl_pkg::axi_lite_resp_t)
  ) i_axi_lite_regs (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .axi_req_i  (axi_lite_slave_req_i),
    .axi_resp_o (axi_lite_slave_resp_o),
    .wr_active_o(wr_active),
    .reg_d_i    (reg_d),
    .reg_load_i (RegLoad),
    .reg_q_o    (reg_q)
  );

  ////////////////////
  // Exit reporting
  ////////////////////

  // Two stages, so the strobe trails the register update by one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_wr_q     <= '0;
      exit_strobe_q <= 1'b0;
    end else begin
      exit_wr_q     <= wr_active[ctrl_pkg::exit];
      exit_strobe_q <= |exit_wr_q;
    end
  end

  assign exit_o           = {reg_q[ctrl_pkg::exit][DataWidth-2:0], exit_strobe_q};
  assign dram_base_addr_o = reg_q[ctrl_pkg::dram_base];
  assign dram_end_addr_o  = reg_q[ctrl_pkg::dram_end];
  assign hw_cnt_en_o      = reg_q[ctrl_pkg::hw_cnt_en];

endmodule : ctrl_registers

// ==== hw/cycle_counter.sv ====
// Free-running 32-bit cycle counter that advances while enabled
module cycle_counter (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        en_i,
  output logic [31:0] count_o
);

  ctrl_pkg::cycle_cnt_t count_q;

  ////////////////////
  // Counter
  ////////////////////

  // Wraps to zero after all ones, holds while disabled
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (en_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

endmodule : cycle_counter

// ==== hw/ctrl_top.sv ====
// Control block top, register file plus the hardware cycle counter
`include "ctrl_defines.svh"

module ctrl_top (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // Host AXI-lite port
  input  ctrl_pkg::axi_lite_req_t       axi_lite_req_i,
  output ctrl_pkg::axi_lite_resp_t      axi_lite_resp_o,
  // SoC status
  output logic [`CTRL_DATA_WIDTH-1:0]   exit_o,
  output logic [`CTRL_DATA_WIDTH-1:0]   dram_base_addr_o,
  output logic [`CTRL_DATA_WIDTH-1:0]   dram_end_addr_o
);

  ////////////////////
  // Internal wires
  ////////////////////

  // Only bit 0 enables the counter
  logic [`CTRL_DATA_WIDTH-1:0] hw_cnt_en;
  logic [31:0]                 cycle_cnt;

  ////////////////////
  // Instances
  ////////////////////

  ctrl_registers #(
    .DRAMBaseAddr(`CTRL_DRAM_BASE),
    .DRAMLength  (`CTRL_DRAM_LENGTH)
  ) i_ctrl_registers (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .axi_lite_slave_req_i (axi_lite_req_i),
    .axi_lite_slave_resp_o(axi_lite_resp_o),
    .cycle_cnt_i          (cycle_cnt),
    .exit_o               (exit_o),
    .dram_base_addr_o     (dram_base_addr_o),
    .dram_end_addr_o      (dram_end_addr_o),
    .hw_cnt_en_o          (hw_cnt_en)
  );

  cycle_counter i_cycle_counter (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .en_i    (hw_cnt_en[0]),
    .count_o (cycle_cnt)
  );

endmodule : ctrl_top

// ==== verif/ctrl_assertions.sv ====
// Handshake stability checks on the AXI-lite port of the register bank
module ctrl_assertions (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input ctrl_pkg::axi_lite_req_t  req_i,
  input ctrl_pkg::axi_lite_resp_t resp_i
);

  // Held responses keep valid and payload
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_i.b_valid && !req_i.b_ready |=> resp_i.b_valid && $stable(resp_i.b))
    else $error("B response changed before it was taken");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_i.r_valid && !req_i.r_ready |=> resp_i.r_valid && $stable(resp_i.r))
    else $error("R response changed before it was taken");

  // Host valids wait for their ready
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i.aw_valid && !resp_i.aw_ready |=> req_i.aw_valid)
    else $error("aw_valid dropped before aw_ready");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i.w_valid && !resp_i.w_ready |=> req_i.w_valid)
    else $error("w_valid dropped before w_ready");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i.ar_valid && !resp_i.ar_ready |=> req_i.ar_valid)
    else $error("ar_valid dropped before ar_ready");

  // An accepted read answers in the next cycle
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i.ar_valid && resp_i.ar_ready |=> resp_i.r_valid)
    else $error("No read response in the cycle after a read was accepted");

endmodule : ctrl_assertions

bind axi_lite_regs ctrl_assertions i_ctrl_assertions (
  .clk_i   (clk_i),
  .arst_n_i(arst_n_i),
  .req_i   (axi_req_i),
  .resp_i  (axi_resp_o)
);

// ==== verif/ctrl_tb.sv ====
// Table-driven AXI-lite testbench for the SoC control block
`include "ctrl_defines.svh"

module ctrl_tb;

  localparam int unsigned MaxWait = 20;
  localparam logic [31:0] Base    = `CTRL_DRAM_BASE;
  // Default base plus default length
  localparam logic [31:0] DramEnd = 32'h8100_0000;
  localparam logic [1:0]  Ok      = 2'b00;
  localparam logic [1:0]  Err     = 2'b10;

  // Plain read, read above the last count, read equal to the last count
  typedef enum logic [1:0] {WR, RD, RD_MORE, RD_SAME} kind_e;

  typedef struct packed {
    kind_e       kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
  } entry_t;

  // kind, address, data, strobe, expected data, expected response
  entry_t tbl [23] = '{
    '{RD,      32'h04, 32'h0,          4'h0, Base,           Ok},
    '{RD,      32'h08, 32'h0,          4'h0, DramEnd,        Ok},
    '{WR,      32'h00, 32'h1234_5678,  4'hF, 32'h0,          Ok},
    '{RD,      32'h00, 32'h0,          4'h0, 32'h1234_5678,  Ok},
    '{WR,      32'h00, 32'hAABB_CCDD,  4'h5, 32'h0,          Ok},
    '{RD,      32'h03, 32'h0,          4'h0, 32'h12BB_56DD,  Ok},
    '{WR,      32'h0C, 32'hFFFF_FF00,  4'h2, 32'h0,          Ok},
    '{RD,      32'h0C, 32'h0,          4'h0, 32'h0000_FF00,  Ok},
    '{WR,      32'h04, 32'h0,          4'hF, 32'h0,          Err},
    '{RD,      32'h04, 32'h0,          4'h0, Base,           Ok},
    '{WR,      32'h10, 32'hFFFF_FFFF,  4'h1, 32'h0,          Err},
    '{RD,      32'h10, 32'h0,          4'h0, 32'h0,          Ok},
    '{RD_SAME, 32'h10, 32'h0,          4'h0, 32'h0,          Ok},
    '{WR,      32'h20, 32'hDEAD_BEEF,  4'hF, 32'h0,          Err},
    '{RD,      32'h20, 32'h0,          4'h0, 32'h0,          Err},
    '{WR,      32'h0C, 32'h1,          4'hF, 32'h0,          Ok},
    '{RD_MORE, 32'h10, 32'h0,          4'h0, 32'h0,          Ok},
    '{RD_MORE, 32'h10, 32'h0,          4'h0, 32'h0,          Ok},
    '{WR,      32'h0C, 32'h0,          4'hF, 32'h0,          Ok},
    '{RD_MORE, 32'h10, 32'h0,          4'h0, 32'h0,          Ok},
    '{RD_SAME, 32'h10, 32'h0,          4'h0, 32'h0,          Ok},
    '{WR,      32'h00, 32'h8000_0003,  4'hF, 32'h0,          Ok},
    '{RD,      32'h00, 32'h0,          4'h0, 32'h8000_0003,  Ok}
  };

  logic                     clk = 1'b0;
  logic                     arst_n;
  ctrl_pkg::axi_lite_req_t  req;
  ctrl_pkg::axi_lite_resp_t resp;
  logic [31:0]              exit_val;
  logic [31:0]              dram_base;
  logic [31:0]              dram_end;
  integer                   seed = 32'h48de_3c9b;
  int unsigned              errors = 0;
  int unsigned              checks = 0;
  int unsigned              exit_writes = 0;
  int unsigned              exit_pulses = 0;
  logic [31:0]              exit_model = '0;
  logic [31:0]              last_cnt = '0;
  logic                     exit_prev = 1'b0;
  logic                     timed_out = 1'b0;

  always #10 clk = ~clk;

  ctrl_top i_dut (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .axi_lite_req_i  (req),
    .axi_lite_resp_o (resp),
    .exit_o          (exit_val),
    .dram_base_addr_o(dram_base),
    .dram_end_addr_o (dram_end)
  );

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout while waiting for %s at time %0t", what, $time);
  endtask

  // Random back-pressure on B and R
  task automatic ready_delay();
    int unsigned d;
    d = $unsigned($random(seed)) % 4;
    repeat (d) @(negedge clk);
  endtask

  task automatic axi_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                           output logic [1:0] bresp);
    int unsigned n;
    n            = 0;
    bresp        = 2'bxx;
    req.aw.addr  = addr;
    req.w.data   = data;
    req.w.strb   = strb;
    req.aw_valid = 1'b1;
    req.w_valid  = 1'b1;
    @(negedge clk);
    while (!resp.b_valid && n < MaxWait) begin
      @(negedge clk);
      n++;
    end
    if (!resp.b_valid) begin
      report_timeout("a write response");
    end else begin
      // Pending B blocks the next write
      check_value("aw_ready", resp.aw_ready, 1'b0);
      check_value("w_ready", resp.w_ready, 1'b0);
      req.aw_valid = 1'b0;
      req.w_valid  = 1'b0;
      // Exit register image, one strobe pulse per accepted write
      if (addr[31:2] == 0 && strb != 0) begin
        exit_writes++;
        for (int i = 0; i < 4; i++) begin
          if (strb[i]) exit_model[8*i +: 8] = data[8*i +: 8];
        end
      end
      ready_delay();
      bresp       = resp.b.resp;
      req.b_ready = 1'b1;
      @(negedge clk);
      req.b_ready = 1'b0;
    end
  endtask

  task automatic axi_read(logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] rresp);
    int unsigned n;
    n            = 0;
    data         = 'x;
    rresp        = 2'bxx;
    req.ar.addr  = addr;
    req.ar_valid = 1'b1;
    @(negedge clk);
    while (!resp.r_valid && n < MaxWait) begin
      @(negedge clk);
      n++;
    end
    if (!resp.r_valid) begin
      report_timeout("a read response");
    end else begin
      req.ar_valid = 1'b0;
      ready_delay();
      data        = resp.r.data;
      rresp       = resp.r.resp;
      req.r_ready = 1'b1;
      @(negedge clk);
      req.r_ready = 1'b0;
    end
  endtask

  task automatic apply_entry(entry_t e);
    logic [1:0]  r;
    logic [31:0] d;
    if (e.kind == WR) begin
      axi_write(e.addr, e.data, e.strb, r);
      if (!timed_out) check_value("b.resp", r, e.exp_resp);
    end else begin
      axi_read(e.addr, d, r);
      if (!timed_out) begin
        check_value("r.resp", r, e.exp_resp);
        if (e.kind == RD) begin
          check_value("r.data", d, e.exp_data);
        end else if (e.kind == RD_SAME) begin
          check_value("r.data", d, last_cnt);
        end else begin
          checks++;
          assert (d > last_cnt) else begin
            errors++;
            $display("[ERROR] %0t r.data: got %h, expected above %h", $time, d, last_cnt);
          end
        end
        if (e.addr[31:2] == 4) last_cnt = d;
      end
    end
  endtask

  ////////////////////
  // Exit monitor
  ////////////////////

  always @(negedge clk) begin
    if (arst_n && exit_val[0]) begin
      exit_pulses++;
      check_value("exit_o[31:1]", {1'b0, exit_val[31:1]}, {1'b0, exit_model[30:0]});
      checks++;
      assert (!exit_prev) else begin
        errors++;
        $display("Exit strobe stayed high for more than one cycle at time %0t", $time);
      end
    end
    exit_prev = exit_val[0];
  end

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    req    = '0;
    arst_n = 1'b0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_value("exit_o", exit_val, 32'h0);
    check_value("dram_base_addr_o", dram_base, Base);
    check_value("dram_end_addr_o", dram_end, DramEnd);
    check_value("aw_ready", resp.aw_ready, 1'b1);
    check_value("w_ready", resp.w_ready, 1'b1);
    check_value("ar_ready", resp.ar_ready, 1'b1);
    check_value("b_valid", resp.b_valid, 1'b0);
    check_value("r_valid", resp.r_valid, 1'b0);
    foreach (tbl[i]) begin
      if (!timed_out) apply_entry(tbl[i]);
    end
    if (!timed_out) begin
      repeat (4) @(negedge clk);
      check_value("exit pulse count", exit_pulses, exit_writes);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : ctrl_tb

// ==== src.f ====
+incdir+hw
hw/ctrl_pkg.sv
hw/axi_lite_regs.sv
hw/ctrl_registers.sv
hw/cycle_counter.sv
hw/ctrl_top.sv
verif/ctrl_assertions.sv
verif/ctrl_tb.sv
